// ==== src/cad_pkg.sv ====
// Convolution engine shared definitions
// Element and accumulator types, image and kernel dimensions
// and the controller phase encoding
package cad_pkg;

  // Data widths
  localparam int PIX_W = 8;
  localparam int ACC_W = 20;

  typedef logic signed [PIX_W-1:0] pixel_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int IMG_DIM   = 8;
  localparam int KER_DIM   = 5;
  localparam int CONV_DIM  = IMG_DIM - KER_DIM + 1;
  // One result per 2x2 pool window
  localparam int POOL_OUTS = (CONV_DIM / 2) * (CONV_DIM / 2);

  // Image row or column, kernel row
  typedef logic [2:0] pos_t;
  typedef logic [2:0] krow_t;

  // Controller phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_WAIT_IDX,
    ST_PROCESS
  } cad_state_t;

endpackage

// ==== src/cad_mem_if.sv ====
// Controller to feature memory link
// Load writes and the five-lane row read request
`timescale 1ns/100ps
interface cad_mem_if #(
  parameter int NUM_MAT = 16
);
  // Write side, data comes from the matrix input
  logic                       wr_en;
  logic                       wr_kernel;
  logic [$clog2(NUM_MAT)-1:0] wr_mat;
  cad_pkg::pos_t              wr_row;
  cad_pkg::pos_t              wr_col;

  // Read side
  logic                       rd_en;
  logic [$clog2(NUM_MAT)-1:0] img_idx;
  logic [$clog2(NUM_MAT)-1:0] ker_idx;
  cad_pkg::pos_t              rd_row;
  cad_pkg::pos_t              rd_col;
  cad_pkg::krow_t             k_row;

  modport ctrl (output wr_en, wr_kernel, wr_mat, wr_row, wr_col,
                output rd_en, img_idx, ker_idx, rd_row, rd_col, k_row);
  modport mem  (input wr_en, wr_kernel, wr_mat, wr_row, wr_col,
                input rd_en, img_idx, ker_idx, rd_row, rd_col, k_row);
endinterface

// ==== src/cad_ctrl.sv ====
// Convolution engine controller
// Phase FSM, load address counters, index capture,
// pool window read sequencing and output credit tracking
`timescale 1ns/100ps
module cad_ctrl #(
  parameter int NUM_MAT   = 16,
  parameter int OUT_DEPTH = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  logic                       in_valid2,
  input  logic [$clog2(NUM_MAT)-1:0] matrix_idx,
  input  logic                       credit,
  cad_mem_if.ctrl                    mem
);
  localparam int IDX_W = $clog2(NUM_MAT);
  localparam int CRD_W = $clog2(OUT_DEPTH + 1);

  cad_pkg::cad_state_t state, state_nxt;

  // Load counters
  logic             load_kernel;
  logic [IDX_W-1:0] mat_cnt;
  cad_pkg::pos_t    row_cnt;
  cad_pkg::pos_t    col_cnt;
  cad_pkg::pos_t    dim_last;
  logic             wr_fire, col_last, row_last, load_last;

  // Request capture
  logic             idx_phase;
  logic [IDX_W-1:0] img_idx_q, ker_idx_q, req_cnt;

  // Window sequencing, seq_cnt is {pool_r, pool_c, sub_r, sub_c}
  logic [3:0]       seq_cnt;
  cad_pkg::krow_t   k_row;
  logic             win_active, win_start, rd_fire, win_last_rd, req_done;
  logic [CRD_W-1:0] credit_cnt;

  assign wr_fire   = in_valid && (state == cad_pkg::ST_IDLE || state == cad_pkg::ST_LOAD);
  assign dim_last  = load_kernel ? cad_pkg::pos_t'(cad_pkg::KER_DIM - 1)
                                 : cad_pkg::pos_t'(cad_pkg::IMG_DIM - 1);
  assign col_last  = col_cnt == dim_last;
  assign row_last  = row_cnt == dim_last;
  assign load_last = wr_fire && load_kernel && col_last && row_last
                     && mat_cnt == IDX_W'(NUM_MAT - 1);

  // A window only starts with a free slot in the result buffer
  assign win_start   = state == cad_pkg::ST_PROCESS && !win_active && credit_cnt != '0;
  assign rd_fire     = state == cad_pkg::ST_PROCESS && (win_active || credit_cnt != '0);
  assign win_last_rd = rd_fire && k_row == cad_pkg::krow_t'(cad_pkg::KER_DIM - 1)
                       && seq_cnt[1:0] == 2'b11;
  assign req_done    = win_last_rd && seq_cnt[3:2] == 2'(cad_pkg::POOL_OUTS - 1);

  // --------------------------------------------------
  // Phase FSM
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      cad_pkg::ST_IDLE:     if (in_valid) state_nxt = cad_pkg::ST_LOAD;
      cad_pkg::ST_LOAD:     if (load_last) state_nxt = cad_pkg::ST_WAIT_IDX;
      cad_pkg::ST_WAIT_IDX: if (in_valid2 && idx_phase) state_nxt = cad_pkg::ST_PROCESS;
      cad_pkg::ST_PROCESS:
        if (req_done)
          state_nxt = (req_cnt == IDX_W'(NUM_MAT - 1)) ? cad_pkg::ST_IDLE
                                                        : cad_pkg::ST_WAIT_IDX;
      default:              state_nxt = cad_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= cad_pkg::ST_IDLE;
      load_kernel <= 1'b0;
      mat_cnt     <= '0;
      row_cnt     <= '0;
      col_cnt     <= '0;
    end
    else
    begin
      state <= state_nxt;
      // Images first, then kernels, row-major
      if (wr_fire)
      begin
        if (!col_last)
          col_cnt <= col_cnt + 1'b1;
        else
        begin
          col_cnt <= '0;
          if (!row_last)
            row_cnt <= row_cnt + 1'b1;
          else
          begin
            row_cnt <= '0;
            if (mat_cnt == IDX_W'(NUM_MAT - 1))
            begin
              mat_cnt     <= '0;
              load_kernel <= ~load_kernel;
            end
            else
              mat_cnt <= mat_cnt + 1'b1;
          end
        end
      end
    end
  end

  // Image index on the first in_valid2 cycle, kernel index on the second
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      idx_phase <= 1'b0;
      img_idx_q <= '0;
      ker_idx_q <= '0;
      req_cnt   <= '0;
    end
    else
    begin
      if (state == cad_pkg::ST_WAIT_IDX && in_valid2)
      begin
        idx_phase <= ~idx_phase;
        if (!idx_phase)
          img_idx_q <= matrix_idx;
        else
          ker_idx_q <= matrix_idx;
      end
      if (req_done)
        req_cnt <= (req_cnt == IDX_W'(NUM_MAT - 1)) ? '0 : req_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // Window reads and credits
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      seq_cnt    <= '0;
      k_row      <= '0;
      win_active <= 1'b0;
      credit_cnt <= CRD_W'(OUT_DEPTH);
    end
    else
    begin
      if (rd_fire)
      begin
        win_active <= !win_last_rd;
        if (k_row == cad_pkg::krow_t'(cad_pkg::KER_DIM - 1))
        begin
          k_row   <= '0;
          seq_cnt <= seq_cnt + 1'b1;
        end
        else
          k_row <= k_row + 1'b1;
      end
      case ({credit, win_start})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  assign mem.wr_en     = wr_fire;
  assign mem.wr_kernel = load_kernel;
  assign mem.wr_mat    = mat_cnt;
  assign mem.wr_row    = row_cnt;
  assign mem.wr_col    = col_cnt;

  // Conv origin is (2*pool_r + sub_r, 2*pool_c + sub_c)
  assign mem.rd_en   = rd_fire;
  assign mem.img_idx = img_idx_q;
  assign mem.ker_idx = ker_idx_q;
  assign mem.rd_row  = cad_pkg::pos_t'({seq_cnt[3], seq_cnt[1]}) + cad_pkg::pos_t'(k_row);
  assign mem.rd_col  = cad_pkg::pos_t'({seq_cnt[2], seq_cnt[0]});
  assign mem.k_row   = k_row;

endmodule

// ==== src/feature_mem.sv ====
// Feature memory
// Holds all images and kernels of a session and returns
// five adjacent image pixels plus one kernel row per read
`timescale 1ns/100ps
module feature_mem #(
  parameter int NUM_MAT = 16
) (
  input  logic            clk,
  input  logic            rst_n,
  input  cad_pkg::pixel_t matrix,
  cad_mem_if.mem          mem,
  output logic            lane_valid,
  output cad_pkg::pixel_t pixels  [cad_pkg::KER_DIM],
  output cad_pkg::pixel_t weights [cad_pkg::KER_DIM]
);

  cad_pkg::pixel_t img_mem [NUM_MAT][cad_pkg::IMG_DIM][cad_pkg::IMG_DIM];
  cad_pkg::pixel_t ker_mem [NUM_MAT][cad_pkg::KER_DIM][cad_pkg::KER_DIM];

  // --------------------------------------------------
  // Load writes
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (mem.wr_en)
    begin
      if (mem.wr_kernel)
        ker_mem[mem.wr_mat][mem.wr_row][mem.wr_col] <= matrix;
      else
        img_mem[mem.wr_mat][mem.wr_row][mem.wr_col] <= matrix;
    end
  end

  // --------------------------------------------------
  // Five-lane row read
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (mem.rd_en)
    begin
      for (int i = 0; i < cad_pkg::KER_DIM; i++)
      begin
        // Lane i sees column rd_col + i of the image row
        pixels[i]  <= img_mem[mem.img_idx][mem.rd_row][mem.rd_col + i];
        weights[i] <= ker_mem[mem.ker_idx][mem.k_row][i];
      end
    end
  end

  // Lane data valid one cycle after the request
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      lane_valid <= 1'b0;
    else
      lane_valid <= mem.rd_en;
  end

endmodule

// ==== src/conv_pool.sv ====
// Convolution and max pool datapath
// Five signed multipliers per kernel row, five rows per conv value,
// running signed maximum over the four values of a pool window
`timescale 1ns/100ps
module conv_pool (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            lane_valid,
  input  cad_pkg::pixel_t pixels  [cad_pkg::KER_DIM],
  input  cad_pkg::pixel_t weights [cad_pkg::KER_DIM],
  output logic            res_valid,
  output cad_pkg::acc_t   res
);
  // Conv positions folded into one pool result
  localparam int POS_PER_WIN = (cad_pkg::CONV_DIM * cad_pkg::CONV_DIM) / cad_pkg::POOL_OUTS;
  localparam int POS_W       = $clog2(POS_PER_WIN);

  cad_pkg::acc_t  row_sum, conv_sum, acc_q, max_q;
  cad_pkg::krow_t row_cnt;
  logic [POS_W-1:0] pos_cnt;
  logic           row_last, pos_last;

  assign row_last = row_cnt == cad_pkg::krow_t'(cad_pkg::KER_DIM - 1);
  assign pos_last = pos_cnt == POS_W'(POS_PER_WIN - 1);

  // Sum of the five lane products, signed throughout
  always_comb
  begin
    row_sum = '0;
    for (int i = 0; i < cad_pkg::KER_DIM; i++)
      row_sum = row_sum + pixels[i] * weights[i];
  end

  // First row of a position restarts the sum
  assign conv_sum = (row_cnt == '0) ? row_sum : acc_q + row_sum;

  // --------------------------------------------------
  // Accumulate and pool
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (lane_valid)
    begin
      acc_q <= conv_sum;
      if (row_last)
      begin
        if (pos_cnt == '0 || conv_sum > max_q)
          max_q <= conv_sum;
        if (pos_last)
          res <= (conv_sum > max_q) ? conv_sum : max_q;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_cnt   <= '0;
      pos_cnt   <= '0;
      res_valid <= 1'b0;
    end
    else
    begin
      res_valid <= lane_valid && row_last && pos_last;
      if (lane_valid)
      begin
        if (row_last)
        begin
          row_cnt <= '0;
          pos_cnt <= pos_last ? '0 : pos_cnt + 1'b1;
        end
        else
          row_cnt <= row_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/out_serializer.sv ====
// Result serializer
// Small result buffer, each entry shifted out MSB first over
// 20 cycles; one credit returned per finished value
`timescale 1ns/100ps
module out_serializer #(
  parameter int OUT_DEPTH = 2
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          res_valid,
  input  cad_pkg::acc_t res,
  output logic          out_valid,
  output logic          out_value,
  output logic          credit
);
  localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CNT_W = $clog2(OUT_DEPTH + 1);
  localparam int BIT_W = $clog2(cad_pkg::ACC_W);

  cad_pkg::acc_t    res_buf [OUT_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [BIT_W-1:0] bit_cnt;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(OUT_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Head entry is the shifter, its MSB is the current bit
  assign out_valid = fill != '0;
  assign out_value = out_valid & res_buf[rd_ptr][cad_pkg::ACC_W-1];
  assign credit    = out_valid && bit_cnt == BIT_W'(cad_pkg::ACC_W - 1);

  // Store and shift never hit the same entry while credits hold
  always_ff @(posedge clk)
  begin
    if (res_valid)
      res_buf[wr_ptr] <= res;
    if (out_valid)
      res_buf[rd_ptr] <= res_buf[rd_ptr] << 1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      if (res_valid)
        wr_ptr <= ptr_inc(wr_ptr);
      if (credit)
      begin
        bit_cnt <= '0;
        rd_ptr  <= ptr_inc(rd_ptr);
      end
      else if (out_valid)
        bit_cnt <= bit_cnt + 1'b1;
      case ({res_valid, credit})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

// ==== src/cad_top.sv ====
// Convolution engine top level
// Loads images and kernels, then answers each index request with
// four max-pooled convolution results on a serial output
`timescale 1ns/100ps
module cad_top #(
  parameter int NUM_MAT   = 16,
  parameter int OUT_DEPTH = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  logic                       in_valid2,
  input  logic [7:0]                 matrix,
  input  logic [$clog2(NUM_MAT)-1:0] matrix_idx,
  output logic                       out_valid,
  output logic                       out_value
);

  logic            credit;
  logic            lane_valid;
  logic            res_valid;
  cad_pkg::pixel_t pixels  [cad_pkg::KER_DIM];
  cad_pkg::pixel_t weights [cad_pkg::KER_DIM];
  cad_pkg::acc_t   res;

  cad_mem_if #(.NUM_MAT(NUM_MAT)) mem_if ();

  cad_ctrl #(
    .NUM_MAT   (NUM_MAT),
    .OUT_DEPTH (OUT_DEPTH)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_valid2  (in_valid2),
    .matrix_idx (matrix_idx),
    .credit     (credit),
    .mem        (mem_if.ctrl)
  );

  feature_mem #(.NUM_MAT(NUM_MAT)) u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .matrix     (matrix),
    .mem        (mem_if.mem),
    .lane_valid (lane_valid),
    .pixels     (pixels),
    .weights    (weights)
  );

  conv_pool u_conv (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_valid (lane_valid),
    .pixels     (pixels),
    .weights    (weights),
    .res_valid  (res_valid),
    .res        (res)
  );

  out_serializer #(.OUT_DEPTH(OUT_DEPTH)) u_ser (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res       (res),
    .out_valid (out_valid),
    .out_value (out_value),
    .credit    (credit)
  );

endmodule

// ==== test/cad_assert.sv ====
// Protocol checks for the convolution engine
// Quiet output during load, known output data while valid,
// and the output credit count kept within its range
`timescale 1ns/100ps
module cad_assert #(
  parameter int OUT_DEPTH = 2
) (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           in_valid,
  input logic                           out_valid,
  input logic                           out_value,
  input logic                           credit,
  input cad_pkg::cad_state_t            state,
  input logic [$clog2(OUT_DEPTH+1)-1:0] credit_cnt
);
  int fail_cnt = 0;

  // --------------------------------------------------
  // Output quiet after reset and while loading
  // --------------------------------------------------
  a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
  else
  begin
    fail_cnt++;
    $error("out_valid is high in the first cycle after reset");
  end

  a_quiet_in_load: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid || state == cad_pkg::ST_LOAD) |-> !out_valid)
  else
  begin
    fail_cnt++;
    $error("out_valid is high while images and kernels are loading");
  end

  // Serial data must be known
  a_value_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_value))
  else
  begin
    fail_cnt++;
    $error("out_value is unknown while out_valid is high");
  end

  // --------------------------------------------------
  // Credit rules
  // --------------------------------------------------
  a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= OUT_DEPTH)
  else
  begin
    fail_cnt++;
    $error("credit count left the range zero to OUT_DEPTH");
  end

  // A returned credit means a value was buffered, so the count cannot be full
  a_credit_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    credit |-> credit_cnt < OUT_DEPTH)
  else
  begin
    fail_cnt++;
    $error("credit returned while the credit count was already full");
  end

endmodule

bind cad_top cad_assert #(.OUT_DEPTH(OUT_DEPTH)) u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid   (in_valid),
  .out_valid  (out_valid),
  .out_value  (out_value),
  .credit     (credit),
  .state      (u_ctrl.state),
  .credit_cnt (u_ctrl.credit_cnt)
);

// ==== test/tb_cad.sv ====
// Testbench for the convolution engine
// Loads random images and kernels, issues index requests and
// checks every serial result against a conv and max pool model
`timescale 1ns/100ps
module tb_cad;
  localparam int NUM_MAT  = 4;
  localparam int IDX_W    = $clog2(NUM_MAT);
  localparam int LOAD_LEN = NUM_MAT * 64 + NUM_MAT * 25;
  localparam int NUM_REQ  = 5;
  localparam int LIMIT    = 2 * LOAD_LEN + NUM_REQ * 400;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic             in_valid2;
  logic [7:0]       matrix;
  logic [IDX_W-1:0] matrix_idx;
  logic             out_valid;
  logic             out_value;

  // Model copies of the loaded data
  int     img [NUM_MAT][8][8];
  int     ker [NUM_MAT][5][5];
  integer seed      = 90;
  int     err_cnt   = 0;
  int     test_cnt  = 0;
  int     test_fail = 0;
  int     cycle_cnt = 0;

  // Serial capture, one queue entry per 20 bits
  logic [19:0] shift_q;
  int          bit_cnt = 0;
  logic [19:0] got_q [$];

  cad_top #(.NUM_MAT(NUM_MAT)) u_cad_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_valid2  (in_valid2),
    .matrix     (matrix),
    .matrix_idx (matrix_idx),
    .out_valid  (out_valid),
    .out_value  (out_value)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic int conv_at(input int m, input int k, input int r, input int c);
    int sum;
    sum = 0;
    for (int kr = 0; kr < 5; kr++)
      for (int kc = 0; kc < 5; kc++)
        sum += img[m][r + kr][c + kc] * ker[k][kr][kc];
    return sum;
  endfunction

  // Max over the 2x2 conv block of pool output p, row-major
  function automatic int pool_at(input int m, input int k, input int p);
    int best;
    int v;
    best = conv_at(m, k, 2 * (p / 2), 2 * (p % 2));
    for (int s = 1; s < 4; s++)
    begin
      v = conv_at(m, k, 2 * (p / 2) + s / 2, 2 * (p % 2) + s % 2);
      if (v > best)
        best = v;
    end
    return best;
  endfunction

  function automatic int total_errors();
    return err_cnt + u_cad_top.u_assert.fail_cnt;
  endfunction

  // Image 3 all +127 and kernel 2 all -128 when extremes is set
  task automatic fill_data(input bit extremes);
    logic signed [7:0] b;
    for (int m = 0; m < NUM_MAT; m++)
    begin
      for (int r = 0; r < 8; r++)
        for (int c = 0; c < 8; c++)
        begin
          b = $random(seed);
          img[m][r][c] = (extremes && m == 3) ? 127 : b;
        end
      for (int r = 0; r < 5; r++)
        for (int c = 0; c < 5; c++)
        begin
          b = $random(seed);
          ker[m][r][c] = (extremes && m == 2) ? -128 : b;
        end
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (total_errors() == errs_before)
      $display("Test %0d %s: ok", test_cnt, name);
    else
    begin
      test_fail++;
      $display("Test %0d %s: %0d errors", test_cnt, name, total_errors() - errs_before);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic send_byte(input int v);
    @(posedge clk);
    #5;
    in_valid = 1'b1;
    matrix   = v[7:0];
  endtask

  // All images first, then all kernels, row-major
  task automatic load_data(input string name);
    int errs;
    errs = total_errors();
    for (int m = 0; m < NUM_MAT; m++)
      for (int i = 0; i < 64; i++)
        send_byte(img[m][i / 8][i % 8]);
    for (int m = 0; m < NUM_MAT; m++)
      for (int i = 0; i < 25; i++)
        send_byte(ker[m][i / 5][i % 5]);
    @(posedge clk);
    #5;
    in_valid = 1'b0;
    matrix   = '0;
    repeat (2) @(posedge clk);
    assert (got_q.size() == 0 && bit_cnt == 0)
    else
    begin
      $display("Output bits appeared during %s", name);
      err_cnt++;
    end
    finish_test(name, errs);
  endtask

  task automatic run_request(input int m, input int k);
    int                exp [4];
    int                errs;
    int                got;
    logic signed [19:0] val;
    errs = total_errors();
    for (int p = 0; p < 4; p++)
      exp[p] = pool_at(m, k, p);
    @(posedge clk);
    #5;
    in_valid2  = 1'b1;
    matrix_idx = IDX_W'(m);
    @(posedge clk);
    #5;
    matrix_idx = IDX_W'(k);
    @(posedge clk);
    #5;
    in_valid2  = 1'b0;
    matrix_idx = '0;
    while (got_q.size() < 4)
      @(posedge clk);
    for (int p = 0; p < 4; p++)
    begin
      val = got_q.pop_front();
      got = val;
      assert (got == exp[p])
      else
      begin
        $display("Fail at %0t: out_value expected %0d, actual %0d", $time, exp[p], got);
        err_cnt++;
      end
    end
    // Nothing may follow the fourth value
    repeat (30) @(posedge clk);
    assert (got_q.size() == 0 && bit_cnt == 0)
    else
    begin
      $display("Extra output bits after the fourth value of image %0d kernel %0d", m, k);
      err_cnt++;
    end
    finish_test($sformatf("request image %0d kernel %0d", m, k), errs);
  endtask

  // Outputs settle after the rising edge, so capture on the falling edge
  always @(negedge clk)
  begin
    if (out_valid)
    begin
      shift_q = {shift_q[18:0], out_value};
      bit_cnt++;
      if (bit_cnt == 20)
      begin
        got_q.push_back(shift_q);
        bit_cnt = 0;
      end
    end
  end

  initial
  begin
    while (cycle_cnt < LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_valid2  = 1'b0;
    matrix     = '0;
    matrix_idx = '0;
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;
    fill_data(1'b1);
    load_data("first load");
    run_request(0, 0);
    run_request(1, 3);
    // Extreme pair, all results most negative
    run_request(3, 2);
    run_request(2, 1);
    // Session over, a fresh load is accepted
    fill_data(1'b0);
    load_data("second load");
    run_request(2, 0);
    $display("Tests: %0d, passed: %0d, failed: %0d, errors: %0d",
             test_cnt, test_cnt - test_fail, test_fail, total_errors());
    if (total_errors() == 0 && test_fail == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/cad_pkg.sv
src/cad_mem_if.sv
src/cad_ctrl.sv
src/feature_mem.sv
src/conv_pool.sv
src/out_serializer.sv
src/cad_top.sv
test/cad_assert.sv
test/tb_cad.sv
